/* Bender.yml */
package:
  name: ooo_core

sources:
  - rtl/ooo_pkg.sv
  - rtl/rename_stage.sv
  - rtl/reservation_station.sv
  - rtl/alu_unit.sv
  - rtl/reorder_buffer.sv
  - rtl/ooo_core.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/ooo_core_properties.sv
      - bench/ooo_core_tb.sv

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset spans the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* bench/ooo_core_properties.sv */
`timescale 1ns/1ps

module ooo_core_properties (
    input logic clk,
    input logic rst,
    input logic in_ready,
    input logic rob_full,
    input logic commit_valid,
    input logic issue_valid,
    input logic cdb_valid
);

    // Read by the testbench to stop the run
    int fail_count = 0;

    // Nothing retires in reset or in the cycle right after it
    commit_quiet_in_reset: assert property (
        @(posedge clk) rst |=> !commit_valid ##1 !commit_valid
    ) else begin
        fail_count++;
        $error("commit_valid went high during reset or in the first cycle after it");
    end

    full_rob_blocks_input: assert property (
        @(posedge clk) disable iff (rst) rob_full |-> !in_ready
    ) else begin
        fail_count++;
        $error("in_ready is high while the ROB is full");
    end

    // Two ALU stages between issue and broadcast, in both directions
    issue_to_cdb: assert property (
        @(posedge clk) disable iff (rst) issue_valid |-> ##2 cdb_valid
    ) else begin
        fail_count++;
        $error("no CDB broadcast two cycles after an issue");
    end

    cdb_from_issue: assert property (
        @(posedge clk) disable iff (rst) cdb_valid |-> $past(issue_valid, 2)
    ) else begin
        fail_count++;
        $error("CDB broadcast without an issue two cycles earlier");
    end

endmodule

bind ooo_core ooo_core_properties u_props (
    .clk(clk),
    .rst(rst),
    .in_ready(in_ready),
    .rob_full(rob_full),
    .commit_valid(commit_valid),
    .issue_valid(issue_valid),
    .cdb_valid(cdb.valid)
);

/* bench/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

    logic    clk;
    logic    rst;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_ready;
    logic    commit_valid;
    commit_t commit;

    // Six words per instruction, room for 64 instructions
    logic [31:0] rows [64*6];

    int          n_instr;
    int          cycle_limit = 100;
    int          cycle_count;
    int          commits_seen;
    int          stall_cycles;
    logic [31:0] rng_state = 32'd32771;

    clock_gen u_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    ooo_core DUT (
        .clk(clk),
        .rst(rst),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .in_ready(in_ready),
        .commit_valid(commit_valid),
        .commit(commit)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s actual 0x%08h expected 0x%08h",
                                name, actual, expected));
        end
    endtask

    // Xorshift32 for the idle gaps
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic instr_t row_instr(input int idx);
        instr_t ins;
        ins.op  = alu_op_e'(rows[6*idx][3:0]);
        ins.rd  = rows[6*idx+1][4:0];
        ins.rs1 = rows[6*idx+2][4:0];
        ins.rs2 = rows[6*idx+3][4:0];
        ins.imm = rows[6*idx+4][15:0];
        return ins;
    endfunction

    task automatic load_program();
        // Unused rows get an op code above the last valid one
        for (int i = 0; i < $size(rows); i++) begin
            rows[i] = {16'hffff, 16'(i)};
        end
        $readmemh("bench/program_input.txt", rows);
        n_instr = 0;
        while (n_instr < $size(rows) / 6 && rows[6*n_instr] <= 32'(OP_ADDI)) begin
            n_instr++;
        end
        if (n_instr == 0) begin
            abort_run("No instructions were found in bench/program_input.txt");
        end
        cycle_limit = 40 * n_instr + 100;
    endtask

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                abort_run($sformatf("Timeout after %0d cycles with %0d of %0d instructions retired",
                                    cycle_count, commits_seen, n_instr));
            end
        end
    end

    // Commit checker, sampled mid-cycle
    initial begin
        commits_seen = 0;
        forever begin
            @(negedge clk);
            if (DUT.u_props.fail_count != 0) begin
                abort_run("A concurrent assertion on the core failed");
            end
            if (!rst && commit_valid) begin
                if (commits_seen >= n_instr) begin
                    abort_run("A commit arrived after the last instruction had retired");
                end else begin
                    check_value("commit.rd", 32'(commit.rd), rows[6*commits_seen+1]);
                    check_value("commit.value", commit.value, rows[6*commits_seen+5]);
                    // ROB tags are handed out in program order around the ring
                    check_value("commit.tag", 32'(commit.tag),
                                32'(commits_seen % ROB_DEPTH));
                    commits_seen++;
                end
            end
        end
    end

    initial begin
        int   gap;
        logic accepted;
        in_valid     = 1'b0;
        in_instr     = '0;
        stall_cycles = 0;
        load_program();
        do @(negedge clk); while (rst);
        @(posedge clk);
        #1;
        for (int idx = 0; idx < n_instr; idx++) begin
            in_instr = row_instr(idx);
            in_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = in_ready;
                if (!accepted) begin
                    stall_cycles++;
                end
                @(posedge clk);
                #1;
            end
            in_valid = 1'b0;
            // The tail of the program goes in back to back
            if (idx + 1 < n_instr - ROB_DEPTH - RS_DEPTH) begin
                gap = int'(next_random() % 4);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
        while (commits_seen < n_instr) begin
            @(posedge clk);
        end
        // Room for a duplicate commit to show up
        repeat (10) @(posedge clk);
        $display("Retired %0d instructions, %0d stall cycles", commits_seen, stall_cycles);
        if (stall_cycles == 0) begin
            abort_run("in_ready never dropped during the back-to-back burst");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* bench/program_input.txt */
// Columns are op rd rs1 rs2 imm expected in hex
// Expected value follows in-order execution of the program
8 01 00 00 0005 00000005
8 02 00 00 fffd fffffffd
0 03 01 02 0000 00000002
1 04 01 02 0000 00000008
2 05 01 02 0000 00000005
3 06 01 02 0000 fffffffd
4 07 01 02 0000 fffffff8
5 08 02 01 0000 00000001
5 09 01 02 0000 00000000
6 0a 01 00 0004 00000050
7 0b 02 00 001c 0000000f
// Write to r0 commits a value but r0 still reads as zero
8 00 01 00 0064 00000069
0 0c 00 01 0000 00000005
// Back-to-back tail with an addi chain ahead of independent work
8 0d 0c 00 0001 00000006
8 0d 0d 00 0001 00000007
8 0d 0d 00 0001 00000008
8 0d 0d 00 0001 00000009
8 0e 00 00 0010 00000010
1 0f 0e 01 0000 0000000b
4 10 04 03 0000 0000000a
6 11 07 00 0001 fffffff0
7 12 06 00 0008 00ffffff
3 13 0e 0f 0000 0000001b
5 14 07 00 0000 00000001
0 15 0d 13 0000 00000024

/* project.f */
rtl/ooo_pkg.sv
rtl/rename_stage.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
bench/clock_gen.sv
bench/ooo_core_properties.sv
bench/ooo_core_tb.sv

/* rtl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue_valid,
    input  dispatch_t issue,
    output cdb_t      cdb
);

    // Stage 1 holds the operation and its operands
    logic     s1_valid;
    alu_op_e  s1_op;
    rob_tag_t s1_tag;
    word_t    s1_a;
    word_t    s1_b;

    word_t    result;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;

    always_comb begin
        case (s1_op)
            OP_ADD, OP_ADDI: result = s1_a + s1_b;
            OP_SUB:          result = s1_a - s1_b;
            OP_AND:          result = s1_a & s1_b;
            OP_OR:           result = s1_a | s1_b;
            OP_XOR:          result = s1_a ^ s1_b;
            OP_SLT:          result = {31'd0, $signed(s1_a) < $signed(s1_b)};
            OP_SLL:          result = s1_a << s1_b[4:0];
            OP_SRL:          result = s1_a >> s1_b[4:0];
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= issue.op;
        s1_tag    <= issue.tag;
        s1_a      <= issue.src1.value;
        s1_b      <= issue.src2.value;
        cdb_tag   <= s1_tag;
        cdb_value <= result;
    end

    assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

endmodule

/* rtl/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    in_ready,
    output logic    commit_valid,
    output commit_t commit
);

    logic      alloc;
    dispatch_t dispatch;
    rob_tag_t  rob_tail;
    logic      rob_full;
    logic      rs_full;
    rob_tag_t  lookup_tag_a;
    rob_tag_t  lookup_tag_b;
    logic      lookup_done_a;
    logic      lookup_done_b;
    word_t     lookup_value_a;
    word_t     lookup_value_b;
    logic      issue_valid;
    dispatch_t issue;
    cdb_t      cdb;

    rename_stage u_rename (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
        .in_ready(in_ready), .alloc(alloc), .dispatch(dispatch),
        .rob_tail(rob_tail), .rob_full(rob_full), .rs_full(rs_full),
        .lookup_tag_a(lookup_tag_a), .lookup_tag_b(lookup_tag_b),
        .lookup_done_a(lookup_done_a), .lookup_done_b(lookup_done_b),
        .lookup_value_a(lookup_value_a), .lookup_value_b(lookup_value_b),
        .cdb(cdb), .commit_valid(commit_valid), .commit(commit)
    );

    reservation_station u_rs (
        .clk(clk), .rst(rst), .alloc(alloc), .dispatch(dispatch), .cdb(cdb),
        .full(rs_full), .issue_valid(issue_valid), .issue(issue)
    );

    alu_unit u_alu (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue), .cdb(cdb)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst), .alloc(alloc), .alloc_rd(in_instr.rd),
        .tail(rob_tail), .full(rob_full), .cdb(cdb),
        .lookup_tag_a(lookup_tag_a), .lookup_tag_b(lookup_tag_b),
        .lookup_done_a(lookup_done_a), .lookup_done_b(lookup_done_b),
        .lookup_value_a(lookup_value_a), .lookup_value_b(lookup_value_b),
        .commit_valid(commit_valid), .commit(commit)
    );

endmodule

/* rtl/ooo_pkg.sv */
package ooo_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int ROB_DEPTH = 8;
    localparam int RS_DEPTH  = 4;

    // Widths with a meaning of their own
    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [2:0]      rob_tag_t;
    typedef logic [15:0]     imm_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_ADDI = 4'd8
    } alu_op_e;

    // Decoded instruction as it enters the core
    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } instr_t;

    // Source operand, either a value or the ROB tag that will produce it
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    typedef struct packed {
        alu_op_e  op;
        rob_tag_t tag;
        operand_t src1;
        operand_t src2;
        imm_t     imm;
    } dispatch_t;

    // Single common data bus lane
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    typedef struct packed {
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    value;
    } commit_t;

endpackage

/* rtl/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  instr_t    in_instr,
    output logic      in_ready,
    output logic      alloc,
    output dispatch_t dispatch,
    input  rob_tag_t  rob_tail,
    input  logic      rob_full,
    input  logic      rs_full,
    output rob_tag_t  lookup_tag_a,
    output rob_tag_t  lookup_tag_b,
    input  logic      lookup_done_a,
    input  logic      lookup_done_b,
    input  word_t     lookup_value_a,
    input  word_t     lookup_value_b,
    input  cdb_t      cdb,
    input  logic      commit_valid,
    input  commit_t   commit
);

    // Architectural values plus the rename map
    word_t            regs [NUM_REGS];
    rob_tag_t         tags [NUM_REGS];
    logic [NUM_REGS-1:0] busy;

    operand_t op_a;
    operand_t op_b;
    logic     use_imm;

    // Register file, then ROB, then the CDB of this cycle
    function automatic operand_t resolve(input reg_idx_t idx, input logic rob_done,
                                         input word_t rob_value);
        operand_t res;
        res.ready = 1'b1;
        res.tag   = tags[idx];
        res.value = regs[idx];
        if (busy[idx]) begin
            if (rob_done) begin
                res.value = rob_value;
            end else if (cdb.valid && cdb.tag == tags[idx]) begin
                res.value = cdb.value;
            end else begin
                res.ready = 1'b0;
            end
        end
        return res;
    endfunction

    assign in_ready = !rob_full && !rs_full;
    assign alloc    = in_valid && in_ready;

    assign lookup_tag_a = tags[in_instr.rs1];
    assign lookup_tag_b = tags[in_instr.rs2];

    always_comb begin
        op_a = resolve(in_instr.rs1, lookup_done_a, lookup_value_a);
        op_b = resolve(in_instr.rs2, lookup_done_b, lookup_value_b);
    end

    assign use_imm = in_instr.op inside {OP_ADDI, OP_SLL, OP_SRL};

    always_comb begin
        dispatch.op   = in_instr.op;
        dispatch.tag  = rob_tail;
        dispatch.src1 = op_a;
        dispatch.src2 = op_b;
        dispatch.imm  = in_instr.imm;
        if (use_imm) begin
            dispatch.src2.ready = 1'b1;
            dispatch.src2.tag   = '0;
            // Shifts take only the amount
            if (in_instr.op == OP_ADDI) begin
                dispatch.src2.value = {{16{in_instr.imm[15]}}, in_instr.imm};
            end else begin
                dispatch.src2.value = {27'd0, in_instr.imm[4:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (commit_valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.value;
                // A younger writer keeps the register busy
                if (tags[commit.rd] == commit.tag) begin
                    busy[commit.rd] <= 1'b0;
                end
            end
            // New mapping wins over a commit to the same register
            if (alloc && in_instr.rd != '0) begin
                busy[in_instr.rd] <= 1'b1;
                tags[in_instr.rd] <= rob_tail;
            end
        end
    end

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc,
    input  reg_idx_t alloc_rd,
    output rob_tag_t tail,
    output logic     full,
    input  cdb_t     cdb,
    input  rob_tag_t lookup_tag_a,
    input  rob_tag_t lookup_tag_b,
    output logic     lookup_done_a,
    output logic     lookup_done_b,
    output word_t    lookup_value_a,
    output word_t    lookup_value_b,
    output logic     commit_valid,
    output commit_t  commit
);

    reg_idx_t rd_q    [ROB_DEPTH];
    word_t    value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;

    rob_tag_t head;
    logic [$clog2(ROB_DEPTH):0] count;
    logic commit_fire;

    assign full        = (count == ROB_DEPTH);
    assign commit_fire = (count != '0) && done[head];

    // Operand forwarding for rename
    assign lookup_done_a  = done[lookup_tag_a];
    assign lookup_done_b  = done[lookup_tag_b];
    assign lookup_value_a = value_q[lookup_tag_a];
    assign lookup_value_b = value_q[lookup_tag_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_fire;
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            if (alloc) begin
                tail       <= tail + 1'b1;
                done[tail] <= 1'b0;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            case ({alloc, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
        // Head entry leaves registered
        commit <= '{tag: head, rd: rd_q[head], value: value_q[head]};
    end

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    input  dispatch_t dispatch,
    input  cdb_t      cdb,
    output logic      full,
    output logic      issue_valid,
    output dispatch_t issue
);

    dispatch_t entry [RS_DEPTH];
    logic [RS_DEPTH-1:0] valid;

    // Age counts the valid entries younger than this one
    logic [$clog2(RS_DEPTH)-1:0] age [RS_DEPTH];

    logic [$clog2(RS_DEPTH)-1:0] sel;
    logic [$clog2(RS_DEPTH)-1:0] best_age;
    logic [$clog2(RS_DEPTH)-1:0] free_idx;

    assign full  = &valid;
    assign issue = entry[sel];

    // Oldest entry with both operands ready
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        best_age    = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid[i] && entry[i].src1.ready && entry[i].src2.ready &&
                (!issue_valid || age[i] > best_age)) begin
                issue_valid = 1'b1;
                sel         = ($clog2(RS_DEPTH))'(i);
                best_age    = age[i];
            end
        end
    end

    always_comb begin
        free_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = ($clog2(RS_DEPTH))'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (alloc && !(issue_valid && age[i] > best_age)) begin
                    age[i] <= age[i] + 1'b1;
                end else if (!alloc && issue_valid && age[i] > best_age) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (issue_valid) begin
                valid[sel] <= 1'b0;
            end
            if (alloc) begin
                valid[free_idx] <= 1'b1;
                age[free_idx]   <= '0;
            end
        end
    end

    // Payload write and CDB wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc && free_idx == i) begin
                entry[i] <= dispatch;
            end else if (cdb.valid) begin
                if (!entry[i].src1.ready && entry[i].src1.tag == cdb.tag) begin
                    entry[i].src1.ready <= 1'b1;
                    entry[i].src1.value <= cdb.value;
                end
                if (!entry[i].src2.ready && entry[i].src2.tag == cdb.tag) begin
                    entry[i].src2.ready <= 1'b1;
                    entry[i].src2.value <= cdb.value;
                end
            end
        end
    end

endmodule
